/* vlog.f */
hw/isa_pkg.sv
hw/proc_pkg.sv
hw/word_ram.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/proc.sv
dv/proc_assertions.sv
dv/proc_tb.sv

/* Makefile */
# Verilator build and run of the proc testbench
VERILATOR ?= verilator
TOP       ?= proc_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass only if the output has the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP OBJ_DIR FILELIST VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/proc_tb.sv */
// Testbench for proc that loads random programs during reset and checks each commit against an ISA model
module proc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int SEED         = 88344;
   localparam int NUM_TESTS    = 40;
   localparam int MAX_LEN      = 40;
   localparam int MEM_WIN      = 8;
   localparam int RESET_CYCLES = 8;
   localparam int HOLD_CYCLES  = 3;
   // Per program the load under reset, execution, halted hold and hand-off
   localparam int TIMEOUT_CYCLES = NUM_TESTS * (MAX_LEN + MAX_LEN + HOLD_CYCLES + 4) + 100;

   // Architectural state of the ISA model
   typedef struct packed {
      isa_pkg::word_t [isa_pkg::NUM_REGS-1:0]   regs;
      isa_pkg::word_t [isa_pkg::DMEM_DEPTH-1:0] dmem;
      isa_pkg::pc_t                             pc;
      logic                                     stopped;
      logic                                     err;
   } model_t;

   logic                 clk = 1'b0;
   logic                 rst_n;
   proc_pkg::prog_load_t prog;
   logic                 err;
   logic                 halted;
   proc_pkg::commit_t    commit;

   isa_pkg::instr_t   prog_mem [isa_pkg::IMEM_DEPTH];
   model_t            model;
   proc_pkg::commit_t expected;
   logic              running;
   logic              test_done;
   int                hold_cnt;
   int                test_errors;
   int                cycle_count = 0;
   int                error_count = 0;
   int                passed = 0;

   proc DUT (.*);

   bind proc proc_assertions checks (.*);

   initial begin
      forever #20 clk = ~clk;
   end

   // Expected trace record for one instruction that also advances the model state
   function automatic proc_pkg::commit_t ref_step(inout model_t st, input isa_pkg::instr_t ins);
      proc_pkg::commit_t c;
      isa_pkg::word_t    a;
      isa_pkg::word_t    b;
      isa_pkg::word_t    d;
      isa_pkg::word_t    imm;
      isa_pkg::word_t    ea;
      isa_pkg::word_t    res;
      logic [11:0]       offs;
      c = '0;
      c.valid = 1'b1;
      c.pc = st.pc;
      c.rd = ins.rd;
      a = st.regs[ins.rs];
      b = st.regs[ins.low[5:3]];
      d = st.regs[ins.rd];
      imm = {{10{ins.low[5]}}, ins.low};
      offs = {ins.rd, ins.rs, ins.low};
      ea = a + imm;
      res = '0;
      st.pc = st.pc + 8'd1;
      case (ins.opcode)
         isa_pkg::OP_ADD:  res = a + b;
         isa_pkg::OP_SUB:  res = a - b;
         isa_pkg::OP_AND:  res = a & b;
         isa_pkg::OP_OR:   res = a | b;
         isa_pkg::OP_XOR:  res = a ^ b;
         isa_pkg::OP_ADDI: res = ea;
         isa_pkg::OP_SLLI: res = a << imm[3:0];
         isa_pkg::OP_SRLI: res = a >> imm[3:0];
         isa_pkg::OP_LD:   res = st.dmem[ea[7:0]];
         isa_pkg::OP_ST: begin
            c.mem_wr = 1'b1;
            c.mem_addr = ea[7:0];
            c.mem_data = d;
            st.dmem[ea[7:0]] = d;
         end
         isa_pkg::OP_BEQZ: begin
            if (d == '0) begin
               st.pc = st.pc + imm[7:0];
            end
         end
         isa_pkg::OP_J:    st.pc = st.pc + offs[7:0];
         isa_pkg::OP_HALT: st.stopped = 1'b1;
         default: begin
            st.stopped = 1'b1;
            st.err = 1'b1;
         end
      endcase
      // Opcodes up to LD write rd and r0 never changes
      if (ins.opcode <= 4'd8 && ins.rd != '0) begin
         c.reg_wr = 1'b1;
         c.wdata = res;
         st.regs[ins.rd] = res;
      end
      return c;
   endfunction

   // Branch and jump offsets stay forward and land on or before the last instruction
   function automatic isa_pkg::instr_t rand_instr(input int pos, input int last);
      isa_pkg::instr_t ins;
      int              kind;
      int              span;
      ins = 16'($urandom);
      kind = $urandom_range(0, 11);
      span = last - pos - 1;
      ins.opcode = 4'(kind);
      if (kind == 8 || kind == 9) begin
         // Loads and stores share a small window based on r0
         ins.rs = '0;
         ins.low = 6'($urandom_range(0, MEM_WIN - 1));
      end else if (kind == 10) begin
         ins.low = 6'($urandom_range(0, (span > 31) ? 31 : span));
      end else if (kind == 11) begin
         {ins.rd, ins.rs, ins.low} = 12'($urandom_range(0, span));
      end
      return ins;
   endfunction

   // Preamble zeroes the data window, then a random body, then HALT or an illegal opcode
   task automatic build_program(input int test_idx, output int len);
      int last;
      len = MEM_WIN + $urandom_range(1, MAX_LEN - MEM_WIN - 1) + 1;
      last = len - 1;
      for (int i = 0; i < MEM_WIN; i++) begin
         prog_mem[i] = '{opcode: isa_pkg::OP_ST, rd: 3'd0, rs: 3'd0, low: 6'(i)};
      end
      for (int i = MEM_WIN; i < last; i++) begin
         prog_mem[i] = rand_instr(i, last);
      end
      prog_mem[last] = 16'($urandom);
      if (test_idx % 4 == 3) begin
         prog_mem[last].opcode = 4'($urandom_range(13, 15));
      end else begin
         prog_mem[last].opcode = isa_pkg::OP_HALT;
      end
   endtask

   // Reset lasts at least RESET_CYCLES and as long as the program load
   task automatic load_and_reset(input int len);
      int n;
      n = (len > RESET_CYCLES) ? len : RESET_CYCLES;
      for (int c = 0; c < n; c++) begin
         @(negedge clk);
         rst_n <= 1'b0;
         prog.we <= (c < len);
         prog.addr <= c[7:0];
         prog.data <= prog_mem[c];
         if (c == n - 1) begin
            running <= 1'b1;
         end
      end
      @(negedge clk);
      rst_n <= 1'b1;
      prog <= '0;
   endtask

   task automatic compare_field(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
      if (got !== exp) begin
         $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic check_commit(input proc_pkg::commit_t got, input proc_pkg::commit_t exp);
      compare_field("commit.valid", 16'(got.valid), 16'(exp.valid));
      compare_field("commit.pc", 16'(got.pc), 16'(exp.pc));
      compare_field("commit.reg_wr", 16'(got.reg_wr), 16'(exp.reg_wr));
      if (exp.reg_wr) begin
         compare_field("commit.rd", 16'(got.rd), 16'(exp.rd));
         compare_field("commit.wdata", got.wdata, exp.wdata);
      end
      compare_field("commit.mem_wr", 16'(got.mem_wr), 16'(exp.mem_wr));
      if (exp.mem_wr) begin
         compare_field("commit.mem_addr", 16'(got.mem_addr), 16'(exp.mem_addr));
         compare_field("commit.mem_data", got.mem_data, exp.mem_data);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
         error_count++;
         test_errors++;
      end
   endtask

   // Commit is combinational from state that changes at the rising edge
   always @(negedge clk) begin
      if (running) begin
         if (!model.stopped) begin
            expected = ref_step(model, prog_mem[model.pc]);
            check_commit(commit, expected);
         end else begin
            check_flag("halted", halted, 1'b1);
            check_flag("err", err, model.err);
            check_flag("commit.valid", commit.valid, 1'b0);
            hold_cnt++;
            if (hold_cnt == HOLD_CYCLES) begin
               test_done <= 1'b1;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a program never reached its stop", cycle_count);
         $display("Test FAILED");
         $finish;
      end
   end

   initial begin
      int len;
      void'($urandom(SEED));
      rst_n = 1'b0;
      prog = '0;
      running = 1'b0;
      test_done = 1'b0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         build_program(t, len);
         model = '0;
         hold_cnt = 0;
         test_errors = 0;
         test_done = 1'b0;
         load_and_reset(len);
         while (!test_done) begin
            @(negedge clk);
         end
         running <= 1'b0;
         @(negedge clk);
         if (test_errors == 0) begin
            passed++;
         end
         $display("Program %0d: %0d instructions, ends in %s, %0d mismatches", t, len,
                  (t % 4 == 3) ? "illegal opcode" : "HALT", test_errors);
      end
      $display("Summary: %0d programs, %0d passed, %0d failed, %0d mismatches", NUM_TESTS,
               passed, NUM_TESTS - passed, error_count);
      if (error_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* dv/proc_assertions.sv */
// Concurrent checks on the status levels and commit trace of proc, attached to it with bind
module proc_assertions (
   input logic              clk,
   input logic              rst_n,
   input logic              err,
   input logic              halted,
   input proc_pkg::commit_t commit
);
   timeunit 1ns;
   timeprecision 100ps;

   // A stopped core keeps its PC
   pc_holds_when_halted: assert property (
      @(posedge clk) disable iff (!rst_n) halted |-> $stable(commit.pc)
   ) else $error("pc moved while halted");

   err_means_halted: assert property (
      @(posedge clk) disable iff (!rst_n) err |-> halted
   ) else $error("err is high while halted is low");

   // Only reset clears halted
   halted_sticky: assert property (
      @(posedge clk) disable iff (!rst_n) halted |=> halted
   ) else $error("halted fell without reset");

endmodule

/* hw/proc.sv */
// Single-cycle processor top level joining fetch, decode, execute and memory
module proc (
   input  logic                 clk,
   input  logic                 rst_n,
   input  proc_pkg::prog_load_t prog,
   output logic                 err,
   output logic                 halted,
   output proc_pkg::commit_t    commit
);

   isa_pkg::pc_t        pc;
   isa_pkg::pc_t        next_pc;
   isa_pkg::instr_t     instr;
   isa_pkg::word_t      alu_result;
   isa_pkg::word_t      wb_data;
   proc_pkg::ctrl_t     ctrl;
   proc_pkg::operands_t opnd;
   logic                stop;
   logic                stop_err;

   fetch fetch0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .prog     (prog),
      .next_pc  (next_pc),
      .stop     (stop),
      .stop_err (stop_err),
      .pc       (pc),
      .instr    (instr),
      .halted   (halted),
      .err      (err)
   );

   decode decode0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .instr   (instr),
      .halted  (halted),
      .wb_data (wb_data),
      .ctrl    (ctrl),
      .opnd    (opnd)
   );

   execute execute0 (
      .pc         (pc),
      .ctrl       (ctrl),
      .opnd       (opnd),
      .alu_result (alu_result),
      .next_pc    (next_pc)
   );

   memory memory0 (
      .clk        (clk),
      .ctrl       (ctrl),
      .opnd       (opnd),
      .alu_result (alu_result),
      .halted     (halted),
      .wb_data    (wb_data),
      .stop       (stop),
      .stop_err   (stop_err)
   );

   // Trace shows only writes that actually land, so r0 writes read as none
   assign commit.valid    = !halted;
   assign commit.pc       = pc;
   assign commit.reg_wr   = !halted && ctrl.reg_wr && instr.rd != '0;
   assign commit.rd       = instr.rd;
   assign commit.wdata    = wb_data;
   assign commit.mem_wr   = !halted && ctrl.mem_wr;
   assign commit.mem_addr = alu_result[isa_pkg::ADDR_W-1:0];
   assign commit.mem_data = opnd.rdata2;

endmodule

/* hw/memory.sv */
// Memory stage with the data RAM, writeback selection and stop detection
module memory (
   input  logic                clk,
   input  proc_pkg::ctrl_t     ctrl,
   input  proc_pkg::operands_t opnd,
   input  isa_pkg::word_t      alu_result,
   input  logic                halted,
   output isa_pkg::word_t      wb_data,
   output logic                stop,
   output logic                stop_err
);

   isa_pkg::pc_t   addr;
   isa_pkg::word_t rdata;

   // Effective address is rs plus imm6, truncated to the RAM size
   assign addr = alu_result[isa_pkg::ADDR_W-1:0];

   word_ram #(
      .payload_t (isa_pkg::word_t),
      .DEPTH     (isa_pkg::DMEM_DEPTH)
   ) dmem (
      .clk   (clk),
      .we    (ctrl.mem_wr && !halted),
      .waddr (addr),
      .raddr (addr),
      .wdata (opnd.rdata2),
      .rdata (rdata)
   );

   assign wb_data = ctrl.mem_rd ? rdata : alu_result;

   // HALT and illegal opcodes both stop the core, only illegal flags an error
   assign stop     = ctrl.halt || ctrl.illegal;
   assign stop_err = ctrl.illegal;

endmodule

/* hw/execute.sv */
// Execute stage with the ALU, the zero test for BEQZ and next-PC selection
module execute (
   input  isa_pkg::pc_t        pc,
   input  proc_pkg::ctrl_t     ctrl,
   input  proc_pkg::operands_t opnd,
   output isa_pkg::word_t      alu_result,
   output isa_pkg::pc_t        next_pc
);

   isa_pkg::word_t              op_b;
   logic [isa_pkg::SHAMT_W-1:0] shamt;
   isa_pkg::pc_t                pc_inc;
   isa_pkg::pc_t                target;
   logic                        taken;

   assign op_b  = ctrl.use_imm ? opnd.imm : opnd.rdata2;
   // Shift amount only from the low bits of the immediate
   assign shamt = op_b[isa_pkg::SHAMT_W-1:0];

   always_comb begin
      unique case (ctrl.alu_op)
         isa_pkg::ALU_ADD: alu_result = opnd.rdata1 + op_b;
         isa_pkg::ALU_SUB: alu_result = opnd.rdata1 - op_b;
         isa_pkg::ALU_AND: alu_result = opnd.rdata1 & op_b;
         isa_pkg::ALU_OR:  alu_result = opnd.rdata1 | op_b;
         isa_pkg::ALU_XOR: alu_result = opnd.rdata1 ^ op_b;
         isa_pkg::ALU_SLL: alu_result = opnd.rdata1 << shamt;
         isa_pkg::ALU_SRL: alu_result = opnd.rdata1 >> shamt;
         default:          alu_result = '0;
      endcase
   end

   // BEQZ tests the rd register, which arrives on rdata2
   assign taken = ctrl.jump || (ctrl.branch && opnd.rdata2 == '0);

   // Targets wrap within the 8-bit instruction space
   assign pc_inc  = pc + 1'b1;
   assign target  = pc_inc + opnd.imm[isa_pkg::ADDR_W-1:0];
   assign next_pc = taken ? target : pc_inc;

endmodule

/* hw/decode.sv */
// Decode stage with the register file, immediate extension and control decoder
module decode (
   input  logic                clk,
   input  logic                rst_n,
   input  isa_pkg::instr_t     instr,
   input  logic                halted,
   input  isa_pkg::word_t      wb_data,
   output proc_pkg::ctrl_t     ctrl,
   output proc_pkg::operands_t opnd
);

   localparam int IMM_PAD  = isa_pkg::WORD_W - isa_pkg::IMM_W;
   localparam int OFFS_PAD = isa_pkg::WORD_W - isa_pkg::OFFS_W;

   isa_pkg::word_t    regs [isa_pkg::NUM_REGS];
   isa_pkg::reg_idx_t rt;
   isa_pkg::reg_idx_t rsel2;
   logic              alu_reg_op;
   logic [isa_pkg::OFFS_W-1:0] offs12;

   assign rt     = instr.low[5:3];
   assign offs12 = {instr.rd, instr.rs, instr.low};

   // Control decoder
   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = isa_pkg::ALU_ADD;
      alu_reg_op  = 1'b0;
      unique case (instr.opcode)
         isa_pkg::OP_ADD: begin
            alu_reg_op  = 1'b1;
            ctrl.reg_wr = 1'b1;
         end
         isa_pkg::OP_SUB: begin
            alu_reg_op  = 1'b1;
            ctrl.alu_op = isa_pkg::ALU_SUB;
            ctrl.reg_wr = 1'b1;
         end
         isa_pkg::OP_AND: begin
            alu_reg_op  = 1'b1;
            ctrl.alu_op = isa_pkg::ALU_AND;
            ctrl.reg_wr = 1'b1;
         end
         isa_pkg::OP_OR: begin
            alu_reg_op  = 1'b1;
            ctrl.alu_op = isa_pkg::ALU_OR;
            ctrl.reg_wr = 1'b1;
         end
         isa_pkg::OP_XOR: begin
            alu_reg_op  = 1'b1;
            ctrl.alu_op = isa_pkg::ALU_XOR;
            ctrl.reg_wr = 1'b1;
         end
         isa_pkg::OP_ADDI: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_wr  = 1'b1;
         end
         isa_pkg::OP_SLLI: begin
            ctrl.alu_op  = isa_pkg::ALU_SLL;
            ctrl.use_imm = 1'b1;
            ctrl.reg_wr  = 1'b1;
         end
         isa_pkg::OP_SRLI: begin
            ctrl.alu_op  = isa_pkg::ALU_SRL;
            ctrl.use_imm = 1'b1;
            ctrl.reg_wr  = 1'b1;
         end
         isa_pkg::OP_LD: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_wr  = 1'b1;
            ctrl.mem_rd  = 1'b1;
         end
         isa_pkg::OP_ST: begin
            ctrl.use_imm = 1'b1;
            ctrl.mem_wr  = 1'b1;
         end
         isa_pkg::OP_BEQZ: ctrl.branch = 1'b1;
         isa_pkg::OP_J:    ctrl.jump   = 1'b1;
         isa_pkg::OP_HALT: ctrl.halt   = 1'b1;
         default:          ctrl.illegal = 1'b1;
      endcase
   end

   // Second read port sees rt for register ops, rd for ST data and BEQZ
   assign rsel2 = alu_reg_op ? rt : instr.rd;

   assign opnd.rdata1 = (instr.rs == '0) ? '0 : regs[instr.rs];
   assign opnd.rdata2 = (rsel2 == '0) ? '0 : regs[rsel2];

   // J uses the wide offset, everything else the 6-bit immediate
   assign opnd.imm = ctrl.jump ? {{OFFS_PAD{offs12[isa_pkg::OFFS_W-1]}}, offs12}
                               : {{IMM_PAD{instr.low[isa_pkg::IMM_W-1]}}, instr.low};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (ctrl.reg_wr && !halted && instr.rd != '0) begin
         regs[instr.rd] <= wb_data;
      end
   end

endmodule

/* hw/fetch.sv */
// Fetch stage holding the PC, the halt and error flags, and the instruction memory
module fetch (
   input  logic                 clk,
   input  logic                 rst_n,
   input  proc_pkg::prog_load_t prog,
   input  isa_pkg::pc_t         next_pc,
   input  logic                 stop,
   input  logic                 stop_err,
   output isa_pkg::pc_t         pc,
   output isa_pkg::instr_t      instr,
   output logic                 halted,
   output logic                 err
);

   // PC freezes on the stopping instruction and flags stay set until reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (!halted) begin
         if (stop) begin
            halted <= 1'b1;
            err    <= stop_err;
         end else begin
            pc <= next_pc;
         end
      end
   end

   // Program is written through the load port, normally during reset
   word_ram #(
      .payload_t (isa_pkg::instr_t),
      .DEPTH     (isa_pkg::IMEM_DEPTH)
   ) imem (
      .clk   (clk),
      .we    (prog.we),
      .waddr (prog.addr),
      .raddr (pc),
      .wdata (prog.data),
      .rdata (instr)
   );

endmodule

/* hw/word_ram.sv */
// Word-addressed RAM with synchronous write and combinational read, used for both memories
module word_ram #(
   parameter type payload_t = isa_pkg::word_t,
   parameter int  DEPTH     = isa_pkg::IMEM_DEPTH
) (
   input  logic         clk,
   input  logic         we,
   input  isa_pkg::pc_t waddr,
   input  isa_pkg::pc_t raddr,
   input  payload_t     wdata,
   output payload_t     rdata
);

   // Plain array indexed by word address
   payload_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Read is asynchronous so an instruction completes in one cycle
   assign rdata = mem[raddr];

endmodule

/* hw/proc_pkg.sv */
// Datapath records passed between the processor stages and to the testbench
package proc_pkg;

   // Decoder output that steers execute, memory and writeback
   typedef struct packed {
      isa_pkg::alu_op_e alu_op;
      logic             use_imm;
      logic             reg_wr;
      logic             mem_rd;
      logic             mem_wr;
      logic             branch;
      logic             jump;
      logic             halt;
      logic             illegal;
   } ctrl_t;

   // Register reads and the sign-extended immediate or offset
   typedef struct packed {
      isa_pkg::word_t rdata1;
      isa_pkg::word_t rdata2;
      isa_pkg::word_t imm;
   } operands_t;

   // Instruction memory load port, written while reset is held
   typedef struct packed {
      logic            we;
      isa_pkg::pc_t    addr;
      isa_pkg::instr_t data;
   } prog_load_t;

   // One record per executed instruction
   typedef struct packed {
      logic              valid;
      isa_pkg::pc_t      pc;
      logic              reg_wr;
      isa_pkg::reg_idx_t rd;
      isa_pkg::word_t    wdata;
      logic              mem_wr;
      isa_pkg::pc_t      mem_addr;
      isa_pkg::word_t    mem_data;
   } commit_t;

endpackage

/* hw/isa_pkg.sv */
// Instruction set definitions (word and instruction formats, opcodes, sizes) shared by all stages
package isa_pkg;

   // Datapath and address widths
   localparam int WORD_W  = 16;
   localparam int ADDR_W  = 8;
   localparam int NUM_REGS = 8;

   // Immediate field widths
   localparam int IMM_W   = 6;
   localparam int OFFS_W  = 12;
   localparam int SHAMT_W = 4;

   // Memory sizes in words
   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [ADDR_W-1:0] pc_t;
   typedef logic [2:0]        reg_idx_t;

   // Opcodes 13 to 15 are not assigned and decode as illegal
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_ADDI = 4'd5,
      OP_SLLI = 4'd6,
      OP_SRLI = 4'd7,
      OP_LD   = 4'd8,
      OP_ST   = 4'd9,
      OP_BEQZ = 4'd10,
      OP_J    = 4'd11,
      OP_HALT = 4'd12
   } opcode_e;

   // Low field carries rt in [5:3] or a signed imm6
   // J joins rd, rs and low into a signed 12-bit offset
   typedef struct packed {
      logic [3:0]       opcode;
      reg_idx_t         rd;
      reg_idx_t         rs;
      logic [IMM_W-1:0] low;
   } instr_t;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLL = 3'd5,
      ALU_SRL = 3'd6
   } alu_op_e;

endpackage
